//--- l1_cache_defs.svh
// L1 cache geometry macros
`ifndef L1_CACHE_DEFS_SVH
`define L1_CACHE_DEFS_SVH

// bus word width in bits
`define L1_WORD_W 32

// number of sets, direct mapped
`define L1_N_SETS 16

// words per line
`define L1_BLOCK_WORDS 2

// index widths
`define L1_SET_W ($clog2(`L1_N_SETS))
`define L1_BLOCK_W ($clog2(`L1_BLOCK_WORDS))

// tag is what remains above set, word and byte offset
`define L1_TAG_W (`L1_WORD_W - `L1_SET_W - `L1_BLOCK_W - 2)

// addresses at or above this go straight to memory
`define L1_NONCACHE_BASE 32'hF000_0000

`endif

//--- l1_cache_pkg.sv
// L1 cache types
package l1_cache_pkg;

`include "l1_cache_defs.svh"

    // one bus word
    typedef logic [`L1_WORD_W-1:0] word_t;

    // processor address fields, msb first
    typedef struct packed {
        logic [`L1_TAG_W-1:0]   tag;
        logic [`L1_SET_W-1:0]   set_idx;
        logic [`L1_BLOCK_W-1:0] word_idx;
        logic [1:0]             byte_off;
    } cache_addr_t;

    // one cache line
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [`L1_TAG_W-1:0]         tag;
        word_t [`L1_BLOCK_WORDS-1:0]  data;
    } cache_frame_t;

    // position of the init / flush walk
    typedef struct packed {
        logic                   finish;   // set once past the last set
        logic [`L1_SET_W-1:0]   set_num;
        logic [`L1_BLOCK_W-1:0] word_num;
    } flush_pos_t;

    // controller states
    typedef enum logic [2:0] {
        INIT,
        READY,
        FETCH,
        WB,
        FLUSH
    } cache_state_t;

endpackage

//--- cache_array_if.sv
// Controller to line array link
`include "l1_cache_defs.svh"

interface cache_array_if
    import l1_cache_pkg::*;
();

    logic [`L1_SET_W-1:0] set_idx;  // set being read and written
    logic                 wen;
    cache_frame_t         wframe;
    cache_frame_t         wmask;    // zero bits get written
    cache_frame_t         rframe;   // follows set_idx
    logic                 hit;

    modport ctrl (
        output set_idx,
        output wen,
        output wframe,
        output wmask,
        input  rframe,
        input  hit
    );

    modport array (
        input  set_idx,
        input  wen,
        input  wframe,
        input  wmask,
        output rframe,
        output hit
    );

endinterface

//--- cache_array.sv
// Direct mapped line storage
`include "l1_cache_defs.svh"

module cache_array
    import l1_cache_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    cache_array_if.array         arr,
    input  logic [`L1_TAG_W-1:0] tag_in
);

    cache_frame_t frames [`L1_N_SETS];
    cache_frame_t cur_frame;

    // masked write, a zero mask bit takes the new value
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `L1_N_SETS; i++) begin
                frames[i] <= '0;
            end
        end else if (arr.wen) begin
            frames[arr.set_idx] <= (frames[arr.set_idx] & arr.wmask)
                                 | (arr.wframe & ~arr.wmask);
        end
    end

    assign cur_frame  = frames[arr.set_idx];    // async read of the indexed set
    assign arr.rframe = cur_frame;

    // tag compare against the live processor address
    assign arr.hit = cur_frame.valid && (cur_frame.tag == tag_in);

endmodule

//--- beat_counters.sv
// Fill beat and walk position counters
`include "l1_cache_defs.svh"

module beat_counters
    import l1_cache_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   beat_step,
    input  logic                   beat_clear,
    input  logic                   walk_step_word,
    input  logic                   walk_step_line,
    input  logic                   walk_clear,
    output logic [`L1_BLOCK_W-1:0] beat_num,
    output logic                   beat_last,
    output flush_pos_t             walk_pos
);

    localparam logic [`L1_BLOCK_W-1:0] LAST_WORD = `L1_BLOCK_W'(`L1_BLOCK_WORDS - 1);

    logic [`L1_SET_W:0] line_up;    // finish and set, one line on
    flush_pos_t         next_line;
    flush_pos_t         next_word;

    assign beat_last = (beat_num == LAST_WORD);

    // the carry out of the last set lands in finish
    assign line_up   = {walk_pos.finish, walk_pos.set_num} + 1'b1;
    assign next_line = {line_up, `L1_BLOCK_W'(0)};

    always_comb begin
        next_word          = walk_pos;
        next_word.word_num = walk_pos.word_num + 1'b1;
        if (walk_pos.word_num == LAST_WORD) begin
            next_word = next_line;  // roll into the next set
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            beat_num <= '0;
            walk_pos <= '0;
        end else begin
            if (beat_clear)
                beat_num <= '0;
            else if (beat_step)
                beat_num <= beat_num + 1'b1;

            if (walk_clear)
                walk_pos <= '0;
            else if (walk_step_line)
                walk_pos <= next_line;  // skip rest of the line
            else if (walk_step_word)
                walk_pos <= next_word;
        end
    end

endmodule

//--- cache_ctrl.sv
// Cache controller FSM
`include "l1_cache_defs.svh"

module cache_ctrl
    import l1_cache_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    // processor bus
    input  logic                   proc_ren,
    input  logic                   proc_wen,
    input  cache_addr_t            proc_addr,
    input  word_t                  proc_wdata,
    input  logic [3:0]             proc_byte_en,
    output word_t                  proc_rdata,
    output logic                   proc_busy,
    // memory bus
    output logic                   mem_ren,
    output logic                   mem_wen,
    output word_t                  mem_addr,
    output word_t                  mem_wdata,
    output logic [3:0]             mem_byte_en,
    input  word_t                  mem_rdata,
    input  logic                   mem_busy,
    // flush
    input  logic                   flush,
    output logic                   flush_done,
    // line array
    cache_array_if.ctrl            arr,
    // counters
    output logic                   beat_step,
    output logic                   beat_clear,
    output logic                   walk_step_word,
    output logic                   walk_step_line,
    output logic                   walk_clear,
    input  logic [`L1_BLOCK_W-1:0] beat_num,
    input  logic                   beat_last,
    input  flush_pos_t             walk_pos
);

    localparam logic [`L1_SET_W-1:0]   LAST_SET  = `L1_SET_W'(`L1_N_SETS - 1);
    localparam logic [`L1_BLOCK_W-1:0] LAST_WORD = `L1_BLOCK_W'(`L1_BLOCK_WORDS - 1);

    cache_state_t state, next_state;
    logic         flush_req;    // flush seen while not ready
    logic         take_flush;
    logic         proc_req;
    logic         pass;
    logic         arr_wen;
    cache_frame_t wframe, wmask;
    word_t        pass_wdata;

    assign proc_req   = proc_ren | proc_wen;
    assign pass       = word_t'(proc_addr) >= `L1_NONCACHE_BASE;
    assign take_flush = flush | flush_req;

    // walk owns the index during init and flush
    assign arr.set_idx = (state == INIT || state == FLUSH) ? walk_pos.set_num
                                                            : proc_addr.set_idx;
    assign arr.wen     = arr_wen;
    assign arr.wframe  = wframe;
    assign arr.wmask   = wmask;

    assign proc_rdata = pass ? mem_rdata : arr.rframe.data[proc_addr.word_idx];

    // zero the disabled lanes on uncached writes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            pass_wdata[8*b +: 8] = proc_byte_en[b] ? proc_wdata[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (state == READY || state == FLUSH)
                flush_req <= 1'b0;  // taken now or already running
            else if (flush)
                flush_req <= 1'b1;
        end
    end

    always_comb begin
        next_state     = state;
        proc_busy      = 1'b1;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = '0;
        mem_wdata      = '0;
        mem_byte_en    = 4'hf;  // whole words for fills and evictions
        flush_done     = 1'b0;
        arr_wen        = 1'b0;
        wframe         = '0;
        wmask          = '1;
        beat_step      = 1'b0;
        beat_clear     = 1'b0;
        walk_step_word = 1'b0;
        walk_step_line = 1'b0;
        walk_clear     = 1'b0;

        case (state)
            INIT: begin
                arr_wen        = 1'b1;  // one set cleared per cycle
                wmask          = '0;
                walk_step_line = 1'b1;
                if (walk_pos.set_num == LAST_SET) begin
                    walk_clear = 1'b1;
                    next_state = READY;
                end
            end
            READY: begin
                if (take_flush) begin
                    next_state = FLUSH;
                end else if (proc_req && pass) begin
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = pass_wdata;
                    mem_byte_en = proc_byte_en;
                    proc_busy   = mem_busy;
                end else if (proc_req && arr.hit) begin
                    proc_busy = 1'b0;
                    if (proc_wen) begin
                        arr_wen      = 1'b1;
                        wframe.dirty = 1'b1;
                        wmask.dirty  = 1'b0;
                        wframe.data[proc_addr.word_idx] = proc_wdata;
                        for (int b = 0; b < 4; b++) begin
                            wmask.data[proc_addr.word_idx][8*b +: 8] = {8{~proc_byte_en[b]}};
                        end
                    end
                end else if (proc_req) begin
                    beat_clear = 1'b1;
                    // dirty victim goes out first
                    next_state = (arr.rframe.valid && arr.rframe.dirty) ? WB : FETCH;
                end
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {proc_addr.tag, proc_addr.set_idx, beat_num, 2'b00};
                // line stays invalid until the last word lands
                wframe.valid          = beat_last;
                wframe.tag            = proc_addr.tag;
                wframe.data[beat_num] = mem_rdata;
                wmask.valid           = 1'b0;
                wmask.dirty           = 1'b0;
                wmask.tag             = '0;
                wmask.data[beat_num]  = '0;
                if (!mem_busy) begin
                    arr_wen   = 1'b1;
                    beat_step = 1'b1;
                    if (beat_last) begin
                        beat_clear = 1'b1;
                        next_state = READY;  // held request hits there
                    end
                end
            end
            WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {arr.rframe.tag, proc_addr.set_idx, beat_num, 2'b00};
                mem_wdata = arr.rframe.data[beat_num];
                if (!mem_busy) begin
                    beat_step = 1'b1;
                    if (beat_last) begin
                        arr_wen     = 1'b1;  // drop valid and dirty
                        wmask.valid = 1'b0;
                        wmask.dirty = 1'b0;
                        beat_clear  = 1'b1;
                        next_state  = FETCH;
                    end
                end
            end
            FLUSH: begin
                if (walk_pos.finish) begin
                    flush_done = 1'b1;
                    walk_clear = 1'b1;
                    next_state = READY;
                end else if (arr.rframe.valid && arr.rframe.dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {arr.rframe.tag, walk_pos.set_num, walk_pos.word_num, 2'b00};
                    mem_wdata = arr.rframe.data[walk_pos.word_num];
                    if (!mem_busy) begin
                        walk_step_word = 1'b1;
                        if (walk_pos.word_num == LAST_WORD) begin
                            arr_wen = 1'b1;  // line written out, clear it
                            wmask   = '0;
                        end
                    end
                end else begin
                    arr_wen        = 1'b1;   // nothing to write back
                    wmask          = '0;
                    walk_step_line = 1'b1;
                end
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

endmodule

//--- l1_cache.sv
// L1 data cache top
module l1_cache
    import l1_cache_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    // processor side
    input  logic       proc_ren,
    input  logic       proc_wen,
    input  word_t      proc_addr,
    input  word_t      proc_wdata,
    input  logic [3:0] proc_byte_en,
    output word_t      proc_rdata,
    output logic       proc_busy,
    // memory side
    output logic       mem_ren,
    output logic       mem_wen,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_byte_en,
    input  word_t      mem_rdata,
    input  logic       mem_busy,
    // flush control
    input  logic       flush,
    output logic       flush_done
);

    cache_addr_t proc_addr_dec;     // field view of the address

    logic       beat_step;
    logic       beat_clear;
    logic       walk_step_word;
    logic       walk_step_line;
    logic       walk_clear;
    logic [$bits(proc_addr_dec.word_idx)-1:0] beat_num;
    logic       beat_last;
    flush_pos_t walk_pos;

    assign proc_addr_dec = proc_addr;

    cache_array_if arr_if ();

    cache_array array0 (
        .CLK    (CLK),
        .nRST   (nRST),
        .arr    (arr_if.array),
        .tag_in (proc_addr_dec.tag)
    );

    beat_counters counters0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .beat_step      (beat_step),
        .beat_clear     (beat_clear),
        .walk_step_word (walk_step_word),
        .walk_step_line (walk_step_line),
        .walk_clear     (walk_clear),
        .beat_num       (beat_num),
        .beat_last      (beat_last),
        .walk_pos       (walk_pos)
    );

    cache_ctrl ctrl0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .proc_ren       (proc_ren),
        .proc_wen       (proc_wen),
        .proc_addr      (proc_addr_dec),
        .proc_wdata     (proc_wdata),
        .proc_byte_en   (proc_byte_en),
        .proc_rdata     (proc_rdata),
        .proc_busy      (proc_busy),
        .mem_ren        (mem_ren),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_byte_en    (mem_byte_en),
        .mem_rdata      (mem_rdata),
        .mem_busy       (mem_busy),
        .flush          (flush),
        .flush_done     (flush_done),
        .arr            (arr_if.ctrl),
        .beat_step      (beat_step),
        .beat_clear     (beat_clear),
        .walk_step_word (walk_step_word),
        .walk_step_line (walk_step_line),
        .walk_clear     (walk_clear),
        .beat_num       (beat_num),
        .beat_last      (beat_last),
        .walk_pos       (walk_pos)
    );

endmodule

//--- tb_mem_model.sv
// Test memory with random stalls
`include "l1_cache_defs.svh"

module tb_mem_model
    import l1_cache_pkg::*;
#(
    parameter logic [31:0] SEED        = 32'h1e68_3f34,
    parameter logic [31:0] CACHED_BASE = 32'h0000_2000
) (
    input  logic       CLK,
    input  logic       ren,
    input  logic       wen,
    input  word_t      addr,
    input  word_t      wdata,
    input  logic [3:0] byte_en,
    output word_t      rdata,
    output logic       busy
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t  image [128];    // 64 cached words, then 64 uncached
    integer seed;

    // uncached flag plus low word bits
    function automatic int word_slot(word_t a);
        return {a[31], a[7:2]};
    endfunction

    // start value mixes every address bit
    function automatic word_t fill_word(word_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    initial begin
        seed = SEED;
        busy = 1'b0;
        for (int i = 0; i < 64; i++) begin
            image[i]      = fill_word(CACHED_BASE + 4 * i);
            image[i + 64] = fill_word(`L1_NONCACHE_BASE + 4 * i);
        end
    end

    assign rdata = ren ? image[word_slot(addr)] : 'x;   // only valid during a read

    // a write lands when busy is low at the edge
    always @(posedge CLK) begin
        if (wen && !busy) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b])
                    image[word_slot(addr)][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        #1;
        busy = ($random(seed) & 3) == 0;   // about one stall in four
    end

endmodule

//--- tb_l1_cache.sv
// L1 cache testbench
`include "l1_cache_defs.svh"

module tb_l1_cache
    import l1_cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    TIMEOUT     = 500;   // cycles per wait
    localparam int    N_RANDOM    = 300;
    localparam word_t CACHED_BASE = 32'h0000_2000;
    localparam word_t BLOCK_MASK  = `L1_BLOCK_WORDS * 4 - 1;

    logic       CLK, nRST;
    logic       proc_ren, proc_wen, proc_busy;
    word_t      proc_addr, proc_wdata, proc_rdata;
    logic [3:0] proc_byte_en, mem_byte_en;
    logic       mem_ren, mem_wen, mem_busy;
    word_t      mem_addr, mem_wdata, mem_rdata;
    logic       flush, flush_done;

    word_t  ref_mem [128];  // same slots as mem0
    integer seed;
    int     edges_since_reset;
    logic   mem_rd_seen, mem_wr_seen;
    word_t  first_mem_rd_addr;

    l1_cache dut0 (.*);

    tb_mem_model #(.SEED(32'h1e68_3f34), .CACHED_BASE(CACHED_BASE)) mem0 (
        .CLK(CLK), .ren(mem_ren), .wen(mem_wen), .addr(mem_addr), .wdata(mem_wdata),
        .byte_en(mem_byte_en), .rdata(mem_rdata), .busy(mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) edges_since_reset <= 0;
        else       edges_since_reset <= edges_since_reset + 1;
    end

    function automatic int word_slot(word_t a);
        return {a[31], a[7:2]};
    endfunction

    function automatic word_t lane_mask(logic [3:0] be);
        word_t m;
        for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{be[b]}};
        return m;
    endfunction

    function automatic word_t cached_addr();
        return CACHED_BASE | word_t'(($random(seed) & 63) << 2);  // 64 words, 2 tags per set
    endfunction

    task automatic expect_word(input word_t got, input word_t exp, input string what);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("FAILED at %0t ns: %s", $time, what);
            $display("Test failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Test failed");
        $fatal(1, "timeout");
    endtask

    // one processor request, held until busy drops
    task automatic bus_access(input logic rd, input word_t addr, input word_t wdata,
                              input logic [3:0] be, output word_t rdata);
        int   waited;
        logic pass;
        pass        = addr >= `L1_NONCACHE_BASE;
        mem_rd_seen = 1'b0;
        mem_wr_seen = 1'b0;
        waited      = 0;
        @(posedge CLK);
        #1;
        proc_ren     = rd;
        proc_wen     = !rd;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        do begin
            @(negedge CLK);
            waited++;
            if (mem_ren && !mem_rd_seen) begin
                mem_rd_seen       = 1'b1;
                first_mem_rd_addr = mem_addr;
            end
            if (pass && mem_wen) begin
                mem_wr_seen = 1'b1;
                expect_true(mem_byte_en == be, "mem_byte_en differs from proc_byte_en");
                expect_word(mem_wdata & ~lane_mask(be), '0, "disabled lanes of mem_wdata");
            end
            if (proc_busy && waited >= TIMEOUT) report_timeout("proc_busy to drop");
        end while (proc_busy);
        expect_true(edges_since_reset >= `L1_N_SETS, "request served before INIT finished");
        if (pass && !rd) expect_true(mem_wr_seen, "uncached write never reached memory");
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    initial begin
        word_t      addr, wdata, rdata, last_wr_addr;
        logic [3:0] be;
        int         waited, done_count;
        seed = 32'h1e68_3f34;
        {proc_ren, proc_wen, flush} = '0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        last_wr_addr = CACHED_BASE;
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
        for (int k = 0; k < 128; k++) ref_mem[k] = mem0.image[k];

        // reads of untouched memory, the first one overlaps INIT
        for (int i = 0; i < 8; i++) begin
            addr = cached_addr();
            bus_access(1'b1, addr, '0, 4'hf, rdata);
            expect_word(rdata, ref_mem[word_slot(addr)], "read before any write");
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            addr = cached_addr();
            if ($random(seed) & 1) begin
                bus_access(1'b1, addr, '0, 4'hf, rdata);
                expect_word(rdata, ref_mem[word_slot(addr)], "cached read");
            end else begin
                wdata = $random(seed);
                be    = $random(seed);
                bus_access(1'b0, addr, wdata, be, rdata);
                ref_mem[word_slot(addr)] = (ref_mem[word_slot(addr)] & ~lane_mask(be))
                                         | (wdata & lane_mask(be));
                last_wr_addr = addr;
            end
        end

        // uncached, small window so reads see earlier writes
        for (int i = 0; i < 16; i++) begin
            addr = `L1_NONCACHE_BASE | word_t'(($random(seed) & 7) << 2);
            if (i % 2 == 0) begin
                wdata = $random(seed);
                be    = $random(seed);
                bus_access(1'b0, addr, wdata, be, rdata);
                ref_mem[word_slot(addr)] = (ref_mem[word_slot(addr)] & ~lane_mask(be))
                                         | (wdata & lane_mask(be));
                expect_word(mem0.image[word_slot(addr)], ref_mem[word_slot(addr)],
                            "uncached write in memory");
            end else begin
                bus_access(1'b1, addr, '0, 4'hf, rdata);
                expect_word(rdata, mem0.image[word_slot(addr)], "uncached read");
            end
        end

        // flush pulse, then watch for flush_done
        @(posedge CLK);
        #1 flush = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
        waited     = 0;
        done_count = 0;
        do begin
            @(negedge CLK);
            waited++;
            if (flush_done) done_count++;
            if (done_count == 0 && waited >= TIMEOUT) report_timeout("flush_done");
        end while (done_count == 0);
        for (int k = 0; k < 2 * `L1_N_SETS; k++) begin
            @(negedge CLK);
            if (flush_done) done_count++;
        end
        expect_true(done_count == 1, "flush_done was high more than once");
        for (int k = 0; k < 64; k++) begin
            expect_word(mem0.image[k], ref_mem[k], "memory image after flush");
        end

        // every line invalid now, so this must refill
        bus_access(1'b1, last_wr_addr, '0, 4'hf, rdata);
        expect_true(mem_rd_seen, "read after flush caused no memory read");
        expect_word(first_mem_rd_addr, last_wr_addr & ~BLOCK_MASK, "refill address");
        expect_word(rdata, ref_mem[word_slot(last_wr_addr)], "read after flush");

        $display("Test passed");
        $finish;
    end

endmodule

//--- l1_cache.f
+incdir+.
l1_cache_pkg.sv
cache_array_if.sv
cache_array.sv
beat_counters.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- Bender.yml
package:
  name: l1_cache

export_include_dirs:
  - .

sources:
  - files:
      - l1_cache_pkg.sv
      - cache_array_if.sv
      - cache_array.sv
      - beat_counters.sv
      - cache_ctrl.sv
      - l1_cache.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_l1_cache.sv
